// File: Makefile
# Verilator build and run for the frame buffer testbench

VERILATOR  ?= verilator
TOP        ?= frame_buf_tb
RTL_TOP    ?= frame_buf_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Everything OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
logic/frame_buf_pkg.sv
logic/pixel_packer.sv
logic/burst_fifo.sv
logic/frame_arbiter.sv
logic/frame_ram.sv
logic/pixel_unpacker.sv
logic/frame_buf_top.sv
test/frame_buf_tb.sv

// File: logic/burst_fifo.sv
`timescale 1ns/1ps

module burst_fifo #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 16,
  parameter int  CNT_W     = $clog2(DEPTH + 1)
) (
  input  logic             clk_board,
  input  logic             i_rst_n,
  input  logic             i_wr_vld,
  input  PAYLOAD_T         i_wr_data,
  input  logic             i_pop,
  output PAYLOAD_T         o_rd_data,
  output logic [CNT_W-1:0] o_count,
  output logic             o_credit,
  output logic             o_overflow
);

  PAYLOAD_T                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic                       full;
  logic                       push;
  logic                       pop;

  assign full = (o_count == CNT_W'(DEPTH));
  assign pop  = i_pop && (o_count != '0);
  // a pop in the same cycle makes room
  assign push = i_wr_vld && (!full || pop);

  // show-ahead read of the oldest entry
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge clk_board) begin
    if (push) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk_board or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_count    <= '0;
      o_credit   <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   o_count <= o_count + 1'b1;
        2'b01:   o_count <= o_count - 1'b1;
        default: o_count <= o_count;
      endcase
      o_credit <= pop;
      // dropped write, held until reset
      if (i_wr_vld && !push) begin
        o_overflow <= 1'b1;
      end
    end
  end

endmodule

// File: logic/frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter (
  input  logic                                 clk_board,
  input  logic                                 i_rst_n,
  input  logic [frame_buf_pkg::CAM_CNT_W-1:0]  i_cam_count,
  input  frame_buf_pkg::cam_beat_t             i_cam_beat,
  output logic                                 o_cam_pop,
  input  logic [frame_buf_pkg::GR_CNT_W-1:0]   i_gr_count,
  input  frame_buf_pkg::gr_write_t             i_gr_write,
  output logic                                 o_gr_pop,
  input  logic                                 i_disp_en,
  input  logic                                 i_disp_credit,
  output logic                                 o_disp_vld,
  output frame_buf_pkg::cam_beat_t             o_disp_beat,
  output frame_buf_pkg::mem_req_t              o_mem_req,
  input  frame_buf_pkg::word_t                 i_mem_rdata
);

  function automatic frame_buf_pkg::grant_t next_peer(input frame_buf_pkg::grant_t g);
    case (g)
      frame_buf_pkg::CAM: next_peer = frame_buf_pkg::GR;
      frame_buf_pkg::GR:  next_peer = frame_buf_pkg::DISP;
      default:            next_peer = frame_buf_pkg::CAM;
    endcase
  endfunction

  frame_buf_pkg::grant_t                 grant;
  frame_buf_pkg::grant_t                 cand_a;
  frame_buf_pkg::grant_t                 cand_b;
  frame_buf_pkg::grant_t                 pick;
  logic [2:0]                            req;
  logic                                  busy;
  logic                                  access;
  logic                                  last;
  logic                                  disp_rd;
  logic [frame_buf_pkg::BURST_CNT_W-1:0] burst_cnt;
  logic [frame_buf_pkg::DISP_CNT_W-1:0]  credits;
  frame_buf_pkg::addr_t                  cam_addr;
  frame_buf_pkg::addr_t                  cam_wr_addr;
  frame_buf_pkg::addr_t                  disp_addr;
  logic                                  rd_pend;
  logic                                  rd_sof;
  logic                                  rd_eof;

  // ==================================================
  // request and round-robin pick
  // ==================================================
  always_comb begin
    req[frame_buf_pkg::CAM]  = |i_cam_count;
    req[frame_buf_pkg::GR]   = |i_gr_count;
    req[frame_buf_pkg::DISP] = i_disp_en && (credits >= frame_buf_pkg::DISP_BURST_CRED);
    // search starts after the last granted peer
    cand_a = next_peer(grant);
    cand_b = next_peer(cand_a);
    if (req[cand_a]) begin
      pick = cand_a;
    end else if (req[cand_b]) begin
      pick = cand_b;
    end else begin
      pick = grant;
    end
  end

  // ==================================================
  // access in the current burst
  // ==================================================
  always_comb begin
    case (grant)
      frame_buf_pkg::CAM: begin
        access = busy && (|i_cam_count);
        // stop on the last entry instead of waiting for empty
        last   = (burst_cnt == frame_buf_pkg::LAST_BEAT) ||
                 !(|i_cam_count[frame_buf_pkg::CAM_CNT_W-1:1]);
      end
      frame_buf_pkg::GR: begin
        access = busy && (|i_gr_count);
        last   = (burst_cnt == frame_buf_pkg::LAST_BEAT) ||
                 !(|i_gr_count[frame_buf_pkg::GR_CNT_W-1:1]);
      end
      default: begin
        access = busy && i_disp_en;
        last   = (burst_cnt == frame_buf_pkg::LAST_BEAT);
      end
    endcase
  end

  assign o_cam_pop   = access && (grant == frame_buf_pkg::CAM);
  assign o_gr_pop    = access && (grant == frame_buf_pkg::GR);
  assign disp_rd     = access && (grant == frame_buf_pkg::DISP);
  // sof beat restarts the frame at word 0
  assign cam_wr_addr = i_cam_beat.sof ? '0 : cam_addr;

  always_comb begin
    o_mem_req.we = access && (grant != frame_buf_pkg::DISP);
    case (grant)
      frame_buf_pkg::CAM: begin
        o_mem_req.addr  = cam_wr_addr;
        o_mem_req.wdata = i_cam_beat.data;
      end
      frame_buf_pkg::GR: begin
        o_mem_req.addr  = i_gr_write.addr;
        o_mem_req.wdata = i_gr_write.data;
      end
      default: begin
        o_mem_req.addr  = disp_addr;
        o_mem_req.wdata = '0;
      end
    endcase
  end

  // ==================================================
  // grant state, addresses and credits
  // ==================================================
  always_ff @(posedge clk_board or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      grant     <= frame_buf_pkg::DISP;
      burst_cnt <= '0;
      cam_addr  <= '0;
      disp_addr <= '0;
      credits   <= frame_buf_pkg::DISP_CRED_INIT;
      rd_pend   <= 1'b0;
    end else begin
      // idle cycle between grants
      if (!busy) begin
        if (|req) begin
          busy      <= 1'b1;
          grant     <= pick;
          burst_cnt <= '0;
        end
      end else if (!access || last) begin
        busy <= 1'b0;
      end else begin
        burst_cnt <= burst_cnt + 1'b1;
      end

      if (o_cam_pop) begin
        cam_addr <= (cam_wr_addr == frame_buf_pkg::LAST_ADDR) ? '0 : cam_wr_addr + 1'b1;
      end

      if (!i_disp_en) begin
        disp_addr <= '0;
      end else if (disp_rd) begin
        disp_addr <= (disp_addr == frame_buf_pkg::LAST_ADDR) ? '0 : disp_addr + 1'b1;
      end

      case ({disp_rd, i_disp_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase

      rd_pend <= disp_rd;
    end
  end

  // frame marks travel alongside the ram read latency
  always_ff @(posedge clk_board) begin
    if (disp_rd) begin
      rd_sof <= (disp_addr == '0);
      rd_eof <= (disp_addr == frame_buf_pkg::LAST_ADDR);
    end
  end

  assign o_disp_vld = rd_pend;

  always_comb begin
    o_disp_beat.sof  = rd_sof;
    o_disp_beat.eof  = rd_eof;
    o_disp_beat.data = i_mem_rdata;
  end

endmodule

// File: logic/frame_buf_pkg.sv
package frame_buf_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int PIX_W          = 8;
  localparam int WORD_W         = 32;
  localparam int PIX_PER_WORD   = 4;
  localparam int ADDR_W         = 8;
  localparam int FRAME_WORDS    = 64;
  localparam int BURST_LEN      = 4;
  localparam int CAM_FIFO_DEPTH = 16;
  localparam int GR_FIFO_DEPTH  = 8;
  localparam int DISP_CREDITS   = 8;

  // derived widths
  localparam int PIX_IDX_W   = $clog2(PIX_PER_WORD);
  localparam int BURST_CNT_W = $clog2(BURST_LEN);
  localparam int CAM_CNT_W   = $clog2(CAM_FIFO_DEPTH + 1);
  localparam int GR_CNT_W    = $clog2(GR_FIFO_DEPTH + 1);
  localparam int DISP_CNT_W  = $clog2(DISP_CREDITS + 1);
  localparam int DISP_PTR_W  = $clog2(DISP_CREDITS);

  // ==================================================
  // types
  // ==================================================
  typedef logic [PIX_W-1:0]  pixel_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef struct packed {
    logic   sof;
    logic   eof;
    pixel_t pix;
  } cam_pix_t;

  typedef struct packed {
    logic  sof;
    logic  eof;
    word_t data;
  } cam_beat_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } gr_write_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // peers in round-robin order
  typedef enum logic [1:0] {
    CAM  = 2'd0,
    GR   = 2'd1,
    DISP = 2'd2
  } grant_t;

  // sized constants for compares
  localparam logic [PIX_IDX_W-1:0]   LAST_PIX        = PIX_IDX_W'(PIX_PER_WORD - 1);
  localparam logic [BURST_CNT_W-1:0] LAST_BEAT       = BURST_CNT_W'(BURST_LEN - 1);
  localparam addr_t                  LAST_ADDR       = addr_t'(FRAME_WORDS - 1);
  localparam logic [DISP_CNT_W-1:0]  DISP_CRED_INIT  = DISP_CNT_W'(DISP_CREDITS);
  localparam logic [DISP_CNT_W-1:0]  DISP_BURST_CRED = DISP_CNT_W'(BURST_LEN);

endpackage

// File: logic/frame_buf_top.sv
`timescale 1ns/1ps

module frame_buf_top (
  input  logic                      clk_board,
  input  logic                      i_rst_n,
  input  logic                      i_cam_vld,
  input  frame_buf_pkg::cam_pix_t   i_cam_pix,
  input  logic                      i_gr_vld,
  input  frame_buf_pkg::gr_write_t  i_gr_write,
  output logic                      o_gr_credit,
  input  logic                      i_disp_en,
  output logic                      o_disp_vld,
  output frame_buf_pkg::cam_pix_t   o_disp_pix,
  input  logic                      i_disp_rdy,
  output logic                      o_cam_overrun
);

  logic                                cam_beat_vld;
  frame_buf_pkg::cam_beat_t            cam_beat;
  frame_buf_pkg::cam_beat_t            cam_fifo_beat;
  logic [frame_buf_pkg::CAM_CNT_W-1:0] cam_count;
  logic                                cam_pop;
  frame_buf_pkg::gr_write_t            gr_fifo_write;
  logic [frame_buf_pkg::GR_CNT_W-1:0]  gr_count;
  logic                                gr_pop;
  logic                                disp_beat_vld;
  frame_buf_pkg::cam_beat_t            disp_beat;
  logic                                disp_credit;
  frame_buf_pkg::mem_req_t             mem_req;
  frame_buf_pkg::word_t                mem_rdata;

  // ==================================================
  // write side
  // ==================================================
  pixel_packer u_packer (
    .clk_board (clk_board),
    .i_rst_n   (i_rst_n),
    .i_vld     (i_cam_vld),
    .i_pix     (i_cam_pix),
    .o_vld     (cam_beat_vld),
    .o_beat    (cam_beat)
  );

  // camera cannot stall, overflow is the overrun flag
  burst_fifo #(
    .PAYLOAD_T (frame_buf_pkg::cam_beat_t),
    .DEPTH     (frame_buf_pkg::CAM_FIFO_DEPTH)
  ) u_cam_fifo (
    .clk_board  (clk_board),
    .i_rst_n    (i_rst_n),
    .i_wr_vld   (cam_beat_vld),
    .i_wr_data  (cam_beat),
    .i_pop      (cam_pop),
    .o_rd_data  (cam_fifo_beat),
    .o_count    (cam_count),
    .o_credit   (),
    .o_overflow (o_cam_overrun)
  );

  // host is credit controlled, so no overflow here
  burst_fifo #(
    .PAYLOAD_T (frame_buf_pkg::gr_write_t),
    .DEPTH     (frame_buf_pkg::GR_FIFO_DEPTH)
  ) u_gr_fifo (
    .clk_board  (clk_board),
    .i_rst_n    (i_rst_n),
    .i_wr_vld   (i_gr_vld),
    .i_wr_data  (i_gr_write),
    .i_pop      (gr_pop),
    .o_rd_data  (gr_fifo_write),
    .o_count    (gr_count),
    .o_credit   (o_gr_credit),
    .o_overflow ()
  );

  // ==================================================
  // shared memory
  // ==================================================
  frame_arbiter u_arbiter (
    .clk_board     (clk_board),
    .i_rst_n       (i_rst_n),
    .i_cam_count   (cam_count),
    .i_cam_beat    (cam_fifo_beat),
    .o_cam_pop     (cam_pop),
    .i_gr_count    (gr_count),
    .i_gr_write    (gr_fifo_write),
    .o_gr_pop      (gr_pop),
    .i_disp_en     (i_disp_en),
    .i_disp_credit (disp_credit),
    .o_disp_vld    (disp_beat_vld),
    .o_disp_beat   (disp_beat),
    .o_mem_req     (mem_req),
    .i_mem_rdata   (mem_rdata)
  );

  frame_ram u_ram (
    .clk_board (clk_board),
    .i_req     (mem_req),
    .o_rdata   (mem_rdata)
  );

  // ==================================================
  // display side
  // ==================================================
  pixel_unpacker u_unpacker (
    .clk_board (clk_board),
    .i_rst_n   (i_rst_n),
    .i_vld     (disp_beat_vld),
    .i_beat    (disp_beat),
    .o_credit  (disp_credit),
    .o_vld     (o_disp_vld),
    .o_pix     (o_disp_pix),
    .i_rdy     (i_disp_rdy)
  );

endmodule

// File: logic/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
  input  logic                    clk_board,
  input  frame_buf_pkg::mem_req_t i_req,
  output frame_buf_pkg::word_t    o_rdata
);

  frame_buf_pkg::word_t mem [2**frame_buf_pkg::ADDR_W];

  // single port, read data one cycle after the request
  always_ff @(posedge clk_board) begin
    if (i_req.we) begin
      mem[i_req.addr] <= i_req.wdata;
    end
    o_rdata <= mem[i_req.addr];
  end

endmodule

// File: logic/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
  input  logic                     clk_board,
  input  logic                     i_rst_n,
  input  logic                     i_vld,
  input  frame_buf_pkg::cam_pix_t  i_pix,
  output logic                     o_vld,
  output frame_buf_pkg::cam_beat_t o_beat
);

  logic [frame_buf_pkg::PIX_IDX_W-1:0] idx;
  logic [frame_buf_pkg::PIX_IDX_W-1:0] cur_idx;
  frame_buf_pkg::word_t                acc;
  frame_buf_pkg::word_t                word_nxt;
  logic                                sof_hold;
  logic                                sof_nxt;
  logic                                close;

  // a sof pixel always opens a fresh word
  always_comb begin
    cur_idx  = i_pix.sof ? '0 : idx;
    word_nxt = i_pix.sof ? '0 : acc;
    word_nxt[cur_idx*frame_buf_pkg::PIX_W +: frame_buf_pkg::PIX_W] = i_pix.pix;
    sof_nxt  = i_pix.sof | sof_hold;
    close    = (cur_idx == frame_buf_pkg::LAST_PIX) || i_pix.eof;
  end

  always_ff @(posedge clk_board or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_vld    <= 1'b0;
      idx      <= '0;
      acc      <= '0;
      sof_hold <= 1'b0;
    end else begin
      o_vld <= i_vld && close;
      if (i_vld) begin
        if (close) begin
          // unused upper bytes stay zero for the next word
          idx      <= '0;
          acc      <= '0;
          sof_hold <= 1'b0;
        end else begin
          idx      <= cur_idx + 1'b1;
          acc      <= word_nxt;
          sof_hold <= sof_nxt;
        end
      end
    end
  end

  always_ff @(posedge clk_board) begin
    if (i_vld && close) begin
      o_beat.sof  <= sof_nxt;
      o_beat.eof  <= i_pix.eof;
      o_beat.data <= word_nxt;
    end
  end

endmodule

// File: logic/pixel_unpacker.sv
`timescale 1ns/1ps

module pixel_unpacker (
  input  logic                     clk_board,
  input  logic                     i_rst_n,
  input  logic                     i_vld,
  input  frame_buf_pkg::cam_beat_t i_beat,
  output logic                     o_credit,
  output logic                     o_vld,
  output frame_buf_pkg::cam_pix_t  o_pix,
  input  logic                     i_rdy
);

  frame_buf_pkg::cam_beat_t             buf_mem [frame_buf_pkg::DISP_CREDITS];
  frame_buf_pkg::cam_beat_t             head;
  logic [frame_buf_pkg::DISP_PTR_W-1:0] wr_ptr;
  logic [frame_buf_pkg::DISP_PTR_W-1:0] rd_ptr;
  logic [frame_buf_pkg::DISP_CNT_W-1:0] count;
  logic [frame_buf_pkg::PIX_IDX_W-1:0]  idx;
  logic                                 xfer;
  logic                                 word_done;

  // word buffer, never overfilled thanks to the credit loop
  always_ff @(posedge clk_board) begin
    if (i_vld) begin
      buf_mem[wr_ptr] <= i_beat;
    end
  end

  assign head      = buf_mem[rd_ptr];
  assign o_vld     = (count != '0);
  assign xfer      = o_vld && i_rdy;
  assign word_done = xfer && (idx == frame_buf_pkg::LAST_PIX);

  // low byte first, marks on the edge pixels
  always_comb begin
    o_pix.pix = head.data[idx*frame_buf_pkg::PIX_W +: frame_buf_pkg::PIX_W];
    o_pix.sof = head.sof && (idx == '0);
    o_pix.eof = head.eof && (idx == frame_buf_pkg::LAST_PIX);
  end

  always_ff @(posedge clk_board or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      idx      <= '0;
      o_credit <= 1'b0;
    end else begin
      if (i_vld) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (xfer) begin
        idx <= idx + 1'b1;
      end
      if (word_done) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_vld, word_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit per freed word
      o_credit <= word_done;
    end
  end

endmodule

// File: test/frame_buf_tb.sv
`timescale 1ns/1ps

module frame_buf_tb;

  localparam int FRAME_PIX  = frame_buf_pkg::FRAME_WORDS * frame_buf_pkg::PIX_PER_WORD;
  localparam int NUM_GR     = 24;
  localparam int OVR_CYCLES = 400;
  // camera pixels take up to 3 cycles, stalled display pixels about 4
  localparam int MAX_CYCLES = 16 + 3 * 2 * FRAME_PIX + 4 * 5 * FRAME_PIX + 8 * NUM_GR
                              + 2 * OVR_CYCLES + 1000;

  logic                     clk_board;
  logic                     i_rst_n;
  logic                     i_cam_vld;
  frame_buf_pkg::cam_pix_t  i_cam_pix;
  logic                     i_gr_vld;
  frame_buf_pkg::gr_write_t i_gr_write;
  logic                     o_gr_credit;
  logic                     i_disp_en;
  logic                     o_disp_vld;
  frame_buf_pkg::cam_pix_t  o_disp_pix;
  logic                     i_disp_rdy;
  logic                     o_cam_overrun;

  integer                   seed;
  int                       cycles;
  int                       host_credits;
  int                       returned;
  int                       npix;
  frame_buf_pkg::word_t     mem_model [frame_buf_pkg::FRAME_WORDS];
  frame_buf_pkg::cam_pix_t  expq [$];

  frame_buf_top dut (
    .clk_board     (clk_board),
    .i_rst_n       (i_rst_n),
    .i_cam_vld     (i_cam_vld),
    .i_cam_pix     (i_cam_pix),
    .i_gr_vld      (i_gr_vld),
    .i_gr_write    (i_gr_write),
    .o_gr_credit   (o_gr_credit),
    .i_disp_en     (i_disp_en),
    .o_disp_vld    (o_disp_vld),
    .o_disp_pix    (o_disp_pix),
    .i_disp_rdy    (i_disp_rdy),
    .o_cam_overrun (o_cam_overrun)
  );

  initial begin
    clk_board = 1'b0;
    forever #20 clk_board = ~clk_board;
  end

  // ==================================================
  // checks
  // ==================================================
  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_pix(input frame_buf_pkg::cam_pix_t got,
                           input frame_buf_pkg::cam_pix_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf(
          "Fail at %0d ns: %s got sof %b eof %b pix %h, expected sof %b eof %b pix %h",
          $time, what, got.sof, got.eof, got.pix, exp.sof, exp.eof, exp.pix));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0d ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  always @(posedge clk_board) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles before the tests finished", cycles));
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  task automatic collect_credit();
    if (o_gr_credit) begin
      host_credits++;
      returned++;
    end
  endtask

  task automatic send_cam_frame(input int n);
    int gap;
    // touched words start at zero so a short tail is padded
    for (int w = 0; w < (n + 3) / frame_buf_pkg::PIX_PER_WORD; w++) begin
      mem_model[w] = '0;
    end
    for (int i = 0; i < n; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(negedge clk_board);
        i_cam_vld = 1'b0;
      end
      @(negedge clk_board);
      i_cam_vld     = 1'b1;
      i_cam_pix.sof = (i == 0);
      i_cam_pix.eof = (i == n - 1);
      i_cam_pix.pix = frame_buf_pkg::pixel_t'($random(seed));
      mem_model[i / 4][(i % 4) * frame_buf_pkg::PIX_W +: frame_buf_pkg::PIX_W] = i_cam_pix.pix;
    end
    @(negedge clk_board);
    i_cam_vld = 1'b0;
    // packer and fifo latency before the count holds the last beat
    repeat (3) @(negedge clk_board);
    while (dut.cam_count != '0) @(negedge clk_board);
  endtask

  task automatic send_gr_writes(input int nwr);
    int issued;
    int w;
    issued   = 0;
    returned = 0;
    while (issued < nwr) begin
      @(negedge clk_board);
      collect_credit();
      i_gr_vld = 1'b0;
      if (host_credits > 0 && ($random(seed) % 2) == 0) begin
        w               = $unsigned($random(seed)) % frame_buf_pkg::FRAME_WORDS;
        i_gr_write.addr = frame_buf_pkg::addr_t'(w);
        i_gr_write.data = frame_buf_pkg::word_t'($random(seed));
        i_gr_vld        = 1'b1;
        mem_model[w]    = i_gr_write.data;
        host_credits--;
        issued++;
      end
    end
    @(negedge clk_board);
    collect_credit();
    i_gr_vld = 1'b0;
    while (host_credits != frame_buf_pkg::GR_FIFO_DEPTH) begin
      @(negedge clk_board);
      collect_credit();
    end
    // no stray credit may follow the last one
    repeat (4) begin
      @(negedge clk_board);
      collect_credit();
    end
    check_flag(returned == nwr, 1'b1, "one credit back per graphics write");
  endtask

  task automatic show_frames(input int nframes, input logic stall);
    logic                    rdy;
    int                      quiet;
    int                      n;
    frame_buf_pkg::cam_pix_t p;
    for (int f = 0; f < nframes; f++) begin
      for (int w = 0; w < frame_buf_pkg::FRAME_WORDS; w++) begin
        for (int b = 0; b < frame_buf_pkg::PIX_PER_WORD; b++) begin
          p.pix = mem_model[w][b * frame_buf_pkg::PIX_W +: frame_buf_pkg::PIX_W];
          p.sof = (w == 0) && (b == 0);
          p.eof = (w == frame_buf_pkg::FRAME_WORDS - 1) && (b == frame_buf_pkg::PIX_PER_WORD - 1);
          expq.push_back(p);
        end
      end
    end
    n = 0;
    @(negedge clk_board);
    i_disp_en = 1'b1;
    while (expq.size() > 0) begin
      @(negedge clk_board);
      rdy        = !stall || (($random(seed) % 4) != 0);
      i_disp_rdy = rdy;
      if (o_disp_vld && rdy) begin
        check_pix(o_disp_pix, expq.pop_front(), $sformatf("display pixel %0d", n));
        n++;
      end
    end
    @(negedge clk_board);
    i_disp_en  = 1'b0;
    i_disp_rdy = 1'b1;
    // words read ahead of the next frame are thrown away
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clk_board);
      quiet = o_disp_vld ? 0 : quiet + 1;
    end
    i_disp_rdy = 1'b0;
  endtask

  task automatic flood_camera();
    int   t;
    logic seen;
    t          = 0;
    seen       = 1'b0;
    i_disp_rdy = 1'b1;
    i_disp_en  = 1'b1;
    while (!seen && t < OVR_CYCLES) begin
      @(negedge clk_board);
      collect_credit();
      // one-pixel words, a beat on every cycle
      i_cam_vld     = 1'b1;
      i_cam_pix.sof = 1'b0;
      i_cam_pix.eof = 1'b1;
      i_cam_pix.pix = frame_buf_pkg::pixel_t'($random(seed));
      i_gr_vld      = 1'b0;
      if (host_credits > 0) begin
        i_gr_write.addr = frame_buf_pkg::addr_t'(
            $unsigned($random(seed)) % frame_buf_pkg::FRAME_WORDS);
        i_gr_write.data = frame_buf_pkg::word_t'($random(seed));
        i_gr_vld        = 1'b1;
        host_credits--;
      end
      seen = o_cam_overrun;
      t++;
    end
    @(negedge clk_board);
    i_cam_vld = 1'b0;
    i_gr_vld  = 1'b0;
    check_flag(o_cam_overrun, 1'b1, "overrun raised by the camera flood");
    repeat (32) @(negedge clk_board);
    check_flag(o_cam_overrun, 1'b1, "overrun still set after the flood");
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    seed         = 32'hc64e;
    cycles       = 0;
    host_credits = frame_buf_pkg::GR_FIFO_DEPTH;
    i_rst_n      = 1'b0;
    i_cam_vld    = 1'b0;
    i_cam_pix    = '0;
    i_gr_vld     = 1'b0;
    i_gr_write   = '0;
    i_disp_en    = 1'b0;
    i_disp_rdy   = 1'b0;
    repeat (16) @(posedge clk_board);
    @(negedge clk_board);
    i_rst_n = 1'b1;
    check_flag(o_disp_vld, 1'b0, "display valid after reset");
    check_flag(o_gr_credit, 1'b0, "graphics credit after reset");
    check_flag(o_cam_overrun, 1'b0, "overrun after reset");

    send_cam_frame(FRAME_PIX);
    show_frames(1, 1'b0);

    send_gr_writes(NUM_GR);
    show_frames(1, 1'b0);

    // eof lands mid-word
    npix = 4 * (8 + $unsigned($random(seed)) % 16) + 1 + $unsigned($random(seed)) % 3;
    send_cam_frame(npix);
    show_frames(1, 1'b0);

    show_frames(2, 1'b1);
    check_flag(o_cam_overrun, 1'b0, "overrun before the flood");

    flood_camera();

    $display("Everything OK");
    $finish;
  end

endmodule
